// File: rtl/cache_consts.svh
// ----------------------------
// cache sizing macros, shared by the RTL and the testbench
// CACHE_BLOCK_WORDS must be a power of two and at least 2
// CACHE_ASSOC is 1 or 2 only
// ----------------------------
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// total data capacity in bytes
`define CACHE_BYTES 1024

// words per block
`define CACHE_BLOCK_WORDS 2

// ways per set
`define CACHE_ASSOC 2

`define CACHE_WORD_W 32
`define CACHE_ADDR_W 32

// rows in each storage array, one row per set
`define CACHE_ROWS \
    (`CACHE_BYTES / (`CACHE_WORD_W / 8) / `CACHE_BLOCK_WORDS / `CACHE_ASSOC)

`endif

// File: rtl/cache_geom_pkg.sv
// ----------------------------
// cache geometry derived from cache_consts.svh
// assumes 4 byte words and power of two set count
// ----------------------------
`include "cache_consts.svh"

package cache_geom_pkg;

    localparam int N_SETS   = `CACHE_ROWS;
    localparam int SET_W    = (N_SETS > 1) ? $clog2(N_SETS) : 1;
    localparam int OFFSET_W = $clog2(`CACHE_BLOCK_WORDS);   // word offset in block
    localparam int BYTE_W   = 2;
    localparam int TAG_W    = `CACHE_ADDR_W - SET_W - OFFSET_W - BYTE_W;
    localparam int WAY_W    = 1;   // enough for 1 or 2 ways

    // byte address split into its cache fields
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [SET_W-1:0]    set;
        logic [OFFSET_W-1:0] offset;
        logic [BYTE_W-1:0]   byte_sel;
    } decoded_addr_t;

    // one frame's bookkeeping
    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef tag_entry_t [`CACHE_ASSOC-1:0] tag_row_t;

    // indexed as [way][word]
    typedef logic [`CACHE_ASSOC-1:0][`CACHE_BLOCK_WORDS-1:0][`CACHE_WORD_W-1:0] data_row_t;

    typedef logic [WAY_W-1:0] way_t;
    typedef logic [SET_W-1:0] set_t;

endpackage

// File: rtl/cache_bus_pkg.sv
// ----------------------------
// types carried on the processor and memory ports
// plus the controller state encoding
// ----------------------------
`include "cache_consts.svh"

package cache_bus_pkg;

    typedef logic [`CACHE_WORD_W-1:0]     word_t;
    typedef logic [`CACHE_WORD_W/8-1:0]   byte_en_t;   // one bit per byte lane
    typedef logic [`CACHE_ADDR_W-1:0]     addr_t;

    // whole block as moved on the memory port, word 0 in the low bits
    typedef logic [`CACHE_BLOCK_WORDS-1:0][`CACHE_WORD_W-1:0] block_t;

    typedef enum logic [2:0] {
        INIT,        // invalidate frames after reset
        LOOKUP,      // serve hits, start misses and flushes
        WRITEBACK,   // dirty victim out to memory
        REFILL,      // block in from memory
        FLUSH        // walk all frames
    } cache_state_t;

endpackage

// File: rtl/cache_array.sv
// ----------------------------
// row memory, async read, write at the clock edge
// a set mask bit keeps the old row bit
// DEPTH must not exceed the range of set_t
// ----------------------------
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_array #(
    parameter type row_t = logic [31:0],
    parameter int  DEPTH = cache_geom_pkg::N_SETS
) (
    input  logic                 CLK,
    input  logic                 nRST,
    input  cache_geom_pkg::set_t sel,
    input  logic                 wen,
    input  row_t                 wmask,
    input  row_t                 wval,
    output row_t                 rval
);

    row_t rows [DEPTH];

    assign rval = rows[sel];   // same-cycle read

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DEPTH; i++) begin
                rows[i] <= '0;
            end
        end else if (wen) begin
            // merge: old bits under the mask, new bits elsewhere
            rows[sel] <= row_t'((rows[sel] & wmask) | (wval & ~wmask));
        end
    end

endmodule

// File: rtl/cache_victim.sv
// ----------------------------
// not-recently-used victim per set
// victim is the way after the last touched one
// direct mapped always picks way 0
// ----------------------------
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_victim (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 touch,
    input  cache_geom_pkg::set_t touch_set,
    input  cache_geom_pkg::way_t touch_way,
    input  cache_geom_pkg::set_t set,
    output cache_geom_pkg::way_t victim
);

    cache_geom_pkg::way_t last_used [cache_geom_pkg::N_SETS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < cache_geom_pkg::N_SETS; i++) begin
                last_used[i] <= '0;
            end
        end else if (touch) begin
            last_used[touch_set] <= touch_way;
        end
    end

    always_comb begin
        if (`CACHE_ASSOC == 1 ||
            last_used[set] == cache_geom_pkg::way_t'(`CACHE_ASSOC - 1)) begin
            victim = '0;   // wrap around
        end else begin
            victim = last_used[set] + 1'b1;
        end
    end

endmodule

// File: rtl/cache_walk_counter.sv
// ----------------------------
// frame walk over every way of every set
// finish is high while the count is on the last frame
// a step from there wraps to set 0, way 0
// ----------------------------
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_walk_counter (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 clear,
    input  logic                 step,
    output cache_geom_pkg::set_t set,
    output cache_geom_pkg::way_t way,
    output logic                 finish
);

    logic last_way;

    assign last_way = (way == cache_geom_pkg::way_t'(`CACHE_ASSOC - 1));
    assign finish   = last_way && (set == cache_geom_pkg::set_t'(cache_geom_pkg::N_SETS - 1));

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            set <= '0;
            way <= '0;
        end else if (clear) begin   // clear wins over step
            set <= '0;
            way <= '0;
        end else if (step) begin
            if (last_way) begin
                way <= '0;
                // next set, or back to the start after the last frame
                if (finish) begin
                    set <= '0;
                end else begin
                    set <= set + 1'b1;
                end
            end else begin
                way <= way + 1'b1;
            end
        end
    end

endmodule

// File: rtl/cache_ctrl.sv
// ----------------------------
// write-back cache controller
// requester holds ren/wen and the address until busy is low
// flush is served at the next LOOKUP cycle, ahead of a request
// ----------------------------
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_ctrl (
    input  logic                      CLK,
    input  logic                      nRST,
    // processor side
    input  logic                      ren,
    input  logic                      wen,
    input  cache_bus_pkg::addr_t      addr,
    input  cache_bus_pkg::word_t      wdata,
    input  cache_bus_pkg::byte_en_t   byte_en,
    output logic                      busy,
    output cache_bus_pkg::word_t      rdata,
    input  logic                      flush,
    output logic                      flush_done,
    output logic                      miss,
    // memory side
    output logic                      mem_ren,
    output logic                      mem_wen,
    output cache_bus_pkg::addr_t      mem_addr,
    output cache_bus_pkg::block_t     mem_store,
    input  logic                      mem_wait,
    input  cache_bus_pkg::block_t     mem_load,
    // storage arrays
    output cache_geom_pkg::set_t      arr_sel,
    output logic                      tag_wen,
    output logic                      data_wen,
    output cache_geom_pkg::tag_row_t  tag_wval,
    output cache_geom_pkg::tag_row_t  tag_wmask,
    output cache_geom_pkg::data_row_t data_wval,
    output cache_geom_pkg::data_row_t data_wmask,
    input  cache_geom_pkg::tag_row_t  tag_rval,
    input  cache_geom_pkg::data_row_t data_rval,
    // victim tracker
    output logic                      touch,
    output cache_geom_pkg::way_t      touch_way,
    input  cache_geom_pkg::way_t      victim,
    // walk counter
    output logic                      walk_clear,
    output logic                      walk_step,
    input  cache_geom_pkg::set_t      walk_set,
    input  cache_geom_pkg::way_t      walk_way,
    input  logic                      walk_finish
);

    cache_bus_pkg::cache_state_t   state, next_state;
    cache_geom_pkg::decoded_addr_t req, miss_addr;
    cache_geom_pkg::way_t          hit_way, miss_way;
    cache_geom_pkg::tag_entry_t    frame;   // frame under the walk
    cache_bus_pkg::word_t          byte_mask;
    logic hit, access, capture;
    logic flush_req, flush_pend;

    // block base address from a tag and a set
    function automatic cache_bus_pkg::addr_t block_addr(
        input logic [cache_geom_pkg::TAG_W-1:0] tag,
        input cache_geom_pkg::set_t             set
    );
        cache_geom_pkg::decoded_addr_t a;
        a     = '0;
        a.tag = tag;
        a.set = set;
        return cache_bus_pkg::addr_t'(a);
    endfunction

    assign req        = cache_geom_pkg::decoded_addr_t'(addr);
    assign access     = ren || wen;
    assign flush_pend = flush || flush_req;
    assign frame      = tag_rval[walk_way];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= cache_bus_pkg::INIT;
            flush_req <= 1'b0;
        end else begin
            state     <= next_state;
            flush_req <= flush_pend && !walk_clear;   // consumed when the walk starts
        end
    end

    // miss bookkeeping, written only when a miss is taken
    always_ff @(posedge CLK) begin
        if (capture) begin
            miss_addr <= req;
            miss_way  <= victim;
        end
    end

    always_comb begin
        for (int b = 0; b < `CACHE_WORD_W / 8; b++) begin
            byte_mask[8*b +: 8] = {8{byte_en[b]}};
        end
    end

    // tag compare over all ways
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < `CACHE_ASSOC; i++) begin
            if (tag_rval[i].valid && tag_rval[i].tag == req.tag) begin
                hit     = 1'b1;
                hit_way = cache_geom_pkg::way_t'(i);
            end
        end
    end

    always_comb begin
        case (state)
            cache_bus_pkg::INIT,
            cache_bus_pkg::FLUSH:     arr_sel = walk_set;
            cache_bus_pkg::WRITEBACK,
            cache_bus_pkg::REFILL:    arr_sel = miss_addr.set;
            default:                  arr_sel = req.set;
        endcase
    end

    always_comb begin
        next_state = state;
        busy       = 1'b1;
        rdata      = '0;
        flush_done = 1'b0;
        miss       = 1'b0;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        mem_addr   = '0;
        mem_store  = '0;
        tag_wen    = 1'b0;
        data_wen   = 1'b0;
        tag_wval   = '0;
        tag_wmask  = '1;   // keep everything unless cleared below
        data_wval  = '0;
        data_wmask = '1;
        touch      = 1'b0;
        touch_way  = hit_way;
        walk_clear = 1'b0;
        walk_step  = 1'b0;
        capture    = 1'b0;

        case (state)
            cache_bus_pkg::INIT: begin
                tag_wen             = 1'b1;   // zero entry, one frame per cycle
                tag_wmask[walk_way] = '0;
                walk_step           = 1'b1;
                if (walk_finish) begin
                    next_state = cache_bus_pkg::LOOKUP;
                end
            end
            cache_bus_pkg::LOOKUP: begin
                if (flush_pend) begin
                    walk_clear = 1'b1;
                    next_state = cache_bus_pkg::FLUSH;
                end else if (access && hit) begin
                    busy  = 1'b0;
                    touch = 1'b1;
                    if (ren) begin
                        rdata = data_rval[hit_way][req.offset];
                    end else begin
                        // byte merge and mark dirty
                        data_wen                         = 1'b1;
                        data_wval[hit_way][req.offset]  = wdata;
                        data_wmask[hit_way][req.offset] = ~byte_mask;
                        tag_wen                          = 1'b1;
                        tag_wval[hit_way].dirty          = 1'b1;
                        tag_wmask[hit_way].dirty         = 1'b0;
                    end
                end else if (access) begin
                    capture = 1'b1;
                    if (tag_rval[victim].valid && tag_rval[victim].dirty) begin
                        next_state = cache_bus_pkg::WRITEBACK;
                    end else begin
                        next_state = cache_bus_pkg::REFILL;
                    end
                end
            end
            cache_bus_pkg::WRITEBACK: begin
                mem_wen   = 1'b1;
                mem_addr  = block_addr(tag_rval[miss_way].tag, miss_addr.set);
                mem_store = data_rval[miss_way];
                if (!mem_wait) begin
                    tag_wen             = 1'b1;   // victim now invalid and clean
                    tag_wmask[miss_way] = '0;
                    next_state          = cache_bus_pkg::LOOKUP;
                end
            end
            cache_bus_pkg::REFILL: begin
                mem_ren  = 1'b1;
                mem_addr = block_addr(miss_addr.tag, miss_addr.set);
                if (!mem_wait) begin
                    miss                 = 1'b1;
                    tag_wen              = 1'b1;
                    tag_wval[miss_way].valid = 1'b1;
                    tag_wval[miss_way].tag   = miss_addr.tag;
                    tag_wmask[miss_way]  = '0;
                    data_wen             = 1'b1;
                    data_wval[miss_way]  = mem_load;
                    data_wmask[miss_way] = '0;
                    next_state           = cache_bus_pkg::LOOKUP;   // request hits there
                end
            end
            cache_bus_pkg::FLUSH: begin
                if (frame.valid && frame.dirty) begin
                    mem_wen   = 1'b1;
                    mem_addr  = block_addr(frame.tag, walk_set);
                    mem_store = data_rval[walk_way];
                    walk_step = !mem_wait;
                end else begin
                    walk_step = 1'b1;
                end
                if (walk_step) begin
                    tag_wen             = 1'b1;
                    tag_wmask[walk_way] = '0;
                    if (walk_finish) begin
                        flush_done = 1'b1;
                        next_state = cache_bus_pkg::LOOKUP;
                    end
                end
            end
            default: next_state = cache_bus_pkg::INIT;
        endcase
    end

endmodule

// File: rtl/l1_cache.sv
// ----------------------------
// L1 data cache top, write-back and write-allocate
// sizes come from cache_consts.svh
// ----------------------------
`timescale 1ns/1ps
`include "cache_consts.svh"

module l1_cache (
    input  logic                    CLK,
    input  logic                    nRST,
    // processor side
    input  logic                    ren,
    input  logic                    wen,
    input  cache_bus_pkg::addr_t    addr,
    input  cache_bus_pkg::word_t    wdata,
    input  cache_bus_pkg::byte_en_t byte_en,
    output logic                    busy,
    output cache_bus_pkg::word_t    rdata,
    input  logic                    flush,
    output logic                    flush_done,
    output logic                    miss,
    // memory side
    output logic                    mem_ren,
    output logic                    mem_wen,
    output cache_bus_pkg::addr_t    mem_addr,
    output cache_bus_pkg::block_t   mem_store,
    input  logic                    mem_wait,
    input  cache_bus_pkg::block_t   mem_load
);

    cache_geom_pkg::set_t      arr_sel, walk_set;
    cache_geom_pkg::way_t      touch_way, victim, walk_way;
    cache_geom_pkg::tag_row_t  tag_wval, tag_wmask, tag_rval;
    cache_geom_pkg::data_row_t data_wval, data_wmask, data_rval;
    logic tag_wen, data_wen, touch;
    logic walk_clear, walk_step, walk_finish;

    cache_ctrl ctrl_i (.*);

    // tags and data share one set select
    cache_array #(
        .row_t (cache_geom_pkg::tag_row_t),
        .DEPTH (cache_geom_pkg::N_SETS)
    ) tag_array_i (
        .CLK, .nRST, .sel(arr_sel), .wen(tag_wen),
        .wmask(tag_wmask), .wval(tag_wval), .rval(tag_rval)
    );

    cache_array #(
        .row_t (cache_geom_pkg::data_row_t),
        .DEPTH (cache_geom_pkg::N_SETS)
    ) data_array_i (
        .CLK, .nRST, .sel(arr_sel), .wen(data_wen),
        .wmask(data_wmask), .wval(data_wval), .rval(data_rval)
    );

    cache_victim victim_i (
        .CLK, .nRST, .touch, .touch_set(arr_sel), .touch_way,
        .set(arr_sel), .victim
    );

    cache_walk_counter walk_i (
        .CLK, .nRST, .clear(walk_clear), .step(walk_step),
        .set(walk_set), .way(walk_way), .finish(walk_finish)
    );

endmodule

// File: verif/l1_cache_asserts.sv
// ----------------------------
// protocol assertions bound into l1_cache
// checked only while out of reset
// ----------------------------
`timescale 1ns/1ps

module l1_cache_asserts (
    input logic                 CLK,
    input logic                 nRST,
    input logic                 mem_ren,
    input logic                 mem_wen,
    input cache_bus_pkg::addr_t mem_addr,
    input logic                 mem_wait,
    input logic                 flush_done
);

    int fail_count = 0;   // read by the testbench at the end

    a_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
    else begin
        fail_count++;
        $error("mem_ren and mem_wen high together");
    end

    // address held while memory stalls
    a_addr_held: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_wait |=> $stable(mem_addr))
    else begin
        fail_count++;
        $error("mem_addr changed during a stalled transfer");
    end

    a_done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done)
    else begin
        fail_count++;
        $error("flush_done longer than one cycle");
    end

endmodule

bind l1_cache l1_cache_asserts asserts_i (.*);

// File: verif/l1_cache_tb.sv
// ----------------------------
// random testbench for l1_cache, fixed seed
// memory model answers with 0 to 3 wait cycles
// addresses stay in a 16 block window, 4 sets x 4 tags
// ----------------------------
`timescale 1ns/1ps
`include "cache_consts.svh"

module l1_cache_tb;

    localparam int MEM_WORDS = 1024;
    localparam int N_OPS     = 600;
    localparam int TIMEOUT   = 200;
    localparam int OFF_W     = cache_geom_pkg::OFFSET_W;

    logic                    CLK, nRST, ren, wen, flush, mem_wait;
    logic                    busy, flush_done, miss, mem_ren, mem_wen;
    cache_bus_pkg::addr_t    addr, mem_addr;
    cache_bus_pkg::word_t    wdata, rdata;
    cache_bus_pkg::byte_en_t byte_en;
    cache_bus_pkg::block_t   mem_store, mem_load;

    integer               seed = 75212;
    cache_bus_pkg::word_t mem_words [MEM_WORDS];   // memory contents
    cache_bus_pkg::word_t ref_words [MEM_WORDS];   // what the processor should see
    bit                   modified [MEM_WORDS >> OFF_W];
    // residency model per set
    bit                   mvalid [cache_geom_pkg::N_SETS][`CACHE_ASSOC];
    logic [cache_geom_pkg::TAG_W-1:0] mtag [cache_geom_pkg::N_SETS][`CACHE_ASSOC];
    int                   mlast [cache_geom_pkg::N_SETS];

    l1_cache l1_cache_i (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input cache_bus_pkg::word_t exp,
                              input cache_bus_pkg::word_t act);
        if (act !== exp)
            stop_on_error($sformatf("[FAIL] %0t %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_block(input string name, input cache_bus_pkg::block_t exp,
                               input cache_bus_pkg::block_t act);
        if (act !== exp)
            stop_on_error($sformatf("[FAIL] %0t %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("[FAIL] %0t %s expected %b got %b", $time, name, exp, act));
    endtask

    function automatic int word_index(input cache_bus_pkg::addr_t a);
        return int'(a[11:2]);
    endfunction

    function automatic cache_bus_pkg::block_t gather(input bit from_ref, input int base);
        cache_bus_pkg::block_t b;
        for (int k = 0; k < `CACHE_BLOCK_WORDS; k++) begin
            b[k] = from_ref ? ref_words[base + k] : mem_words[base + k];
        end
        return b;
    endfunction

    // updates residency, returns 1 when the block was not resident
    function automatic logic model_touch(input cache_bus_pkg::addr_t a);
        cache_geom_pkg::decoded_addr_t d;
        int v;
        d = cache_geom_pkg::decoded_addr_t'(a);
        for (int w = 0; w < `CACHE_ASSOC; w++) begin
            if (mvalid[d.set][w] && mtag[d.set][w] == d.tag) begin
                mlast[d.set] = w;
                return 1'b0;
            end
        end
        v = (mlast[d.set] == `CACHE_ASSOC - 1) ? 0 : mlast[d.set] + 1;   // way after last used
        mvalid[d.set][v] = 1'b1;
        mtag[d.set][v]   = d.tag;
        mlast[d.set]     = v;
        return 1'b1;
    endfunction

    // memory responder, answers after the rising edge, completes at the falling edge
    initial begin
        bit done, active;
        int cnt, base;
        active   = 1'b0;
        done     = 1'b0;
        cnt      = 0;
        mem_wait = 1'b1;
        mem_load = '0;
        forever begin
            @(posedge CLK);
            #1;
            if (done) begin
                active   = 1'b0;
                mem_wait = 1'b1;
            end
            base = word_index(mem_addr);
            if ((mem_ren || mem_wen) && !active) begin
                active = 1'b1;
                cnt    = $random(seed) & 3;   // wait cycles before the answer
            end
            if (active) begin
                if (cnt == 0) begin
                    mem_wait = 1'b0;
                    mem_load = gather(1'b0, base);
                end else begin
                    cnt--;
                end
            end
            @(negedge CLK);
            done = (mem_ren || mem_wen) && !mem_wait;
            base = word_index(mem_addr);
            if (done && mem_wen) begin
                if (!modified[base >> OFF_W])
                    stop_on_error($sformatf("block %h written back without a change", mem_addr));
                check_block("mem_store", gather(1'b1, base), mem_store);
                for (int k = 0; k < `CACHE_BLOCK_WORDS; k++) mem_words[base + k] = mem_store[k];
                modified[base >> OFF_W] = 1'b0;
            end
        end
    end

    task automatic do_access(input bit is_write, input cache_bus_pkg::addr_t a,
                             input cache_bus_pkg::word_t d, input cache_bus_pkg::byte_en_t be);
        int cycles, misses, w;
        bit done;
        logic exp_miss;
        exp_miss = model_touch(a);
        ren      = !is_write;
        wen      = is_write;
        addr     = a;
        wdata    = d;
        byte_en  = be;
        cycles   = 0;
        misses   = 0;
        done     = 1'b0;
        while (!done) begin
            @(negedge CLK);
            if (miss) misses++;
            if (!busy) begin
                done = 1'b1;
            end else begin
                cycles++;
                if (cycles > TIMEOUT)
                    stop_on_error($sformatf("request to %h never completed", a));
            end
        end
        w = word_index(a);
        if (!is_write) begin
            check_word("rdata", ref_words[w], rdata);
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) ref_words[w][8*b +: 8] = d[8*b +: 8];   // byte merge
            end
            modified[w >> OFF_W] = 1'b1;
        end
        if (misses > 1) stop_on_error($sformatf("miss pulsed %0d times for %h", misses, a));
        check_bit("miss", exp_miss, misses == 1);
        @(posedge CLK);
        #1;
        ren = 1'b0;
        wen = 1'b0;
    endtask

    task automatic do_flush();
        int cycles;
        flush = 1'b1;
        @(posedge CLK);
        #1;
        flush  = 1'b0;
        cycles = 0;
        do begin
            @(negedge CLK);
            cycles++;
            if (cycles > TIMEOUT) stop_on_error("flush_done never arrived");
        end while (!flush_done);
        @(posedge CLK);
        #1;
        foreach (mvalid[s, w]) mvalid[s][w] = 1'b0;   // every frame now invalid
        foreach (modified[i]) begin
            if (modified[i]) stop_on_error($sformatf("block %0d still dirty after flush", i));
        end
        for (int i = 0; i < MEM_WORDS; i++) check_word("mem_words", ref_words[i], mem_words[i]);
    endtask

    initial begin
        int b, r;
        cache_bus_pkg::addr_t a;
        cache_bus_pkg::byte_en_t be;
        nRST    = 1'b0;
        ren     = 1'b0;
        wen     = 1'b0;
        flush   = 1'b0;
        addr    = '0;
        wdata   = '0;
        byte_en = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_words[i] = cache_bus_pkg::word_t'(i * 4) ^ 32'hC0DE_5A17;
            ref_words[i] = mem_words[i];
        end
        foreach (mlast[s]) mlast[s] = 0;
        repeat (4) @(posedge CLK);
        #1 nRST = 1'b1;
        // initialization walk, nothing should leave the cache
        repeat (cache_geom_pkg::N_SETS * `CACHE_ASSOC) begin
            @(negedge CLK);
            check_bit("busy", 1'b1, busy);
            check_bit("mem_ren", 1'b0, mem_ren);
            check_bit("mem_wen", 1'b0, mem_wen);
        end
        @(posedge CLK);
        #1;
        do_access(1'b0, 32'h0000_0200, '0, '0);
        for (int n = 0; n < N_OPS; n++) begin
            r = $random(seed) & 31;
            if (r == 0) begin
                do_flush();
            end else begin
                b  = $random(seed) & 15;
                a  = ((b >> 2) + 1) << 9 | (b & 3) << 3 | ($random(seed) & 1) << 2;
                r  = ($random(seed) & 32'h7fff_ffff) % 3;
                be = (r == 0) ? 4'b0001 : (r == 1) ? 4'b0011 : 4'b1111;
                do_access($random(seed) & 1, a, $random(seed), be);
            end
        end
        do_flush();
        if (l1_cache_i.asserts_i.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_on_error("a bound assertion failed during the run");
        end
    end

endmodule

// File: filelist.f
+incdir+rtl
rtl/cache_geom_pkg.sv
rtl/cache_bus_pkg.sv
rtl/cache_array.sv
rtl/cache_victim.sv
rtl/cache_walk_counter.sv
rtl/cache_ctrl.sv
rtl/l1_cache.sv
verif/l1_cache_asserts.sv
verif/l1_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the l1_cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module l1_cache_tb \
    -o l1_cache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/l1_cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ] || ! grep -q "Test OK" "$LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0
